// File: src/rv_pkg.sv
package rv_pkg;

	localparam int XLEN = 64;

	// Major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_SRA  = 4'd9
	} alu_op_e;

	// Write-back source
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_LINK = 2'd2 // PC + 4
	} wb_sel_e;

	typedef struct packed {
		logic       reg_write;
		wb_sel_e    wb_sel;
		alu_op_e    alu_op;
		logic       a_is_pc;    // Operand A is the PC
		logic       b_is_imm;   // Operand B is the immediate
		logic       mem_read;
		logic       mem_write;
		logic [2:0] mem_funct3; // Access size and signedness
		logic       is_branch;
		logic [2:0] br_funct3;
		logic       is_jal;
		logic       is_jalr;
		logic       halt;       // ECALL
	} ctrl_t;

	// One committing instruction
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		logic [4:0]      rd;
		logic [XLEN-1:0] wdata; // Zero when nothing is written
	} retire_t;

endpackage

// File: src/alu.sv
`timescale 1ns/100ps

module alu import rv_pkg::*; (
	input  alu_op_e         op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] y
);
	logic [5:0]      shamt;
	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;
	logic            lt_s;
	logic            lt_u;

	assign shamt = b[5:0]; // RV64 shifts use six bits
	assign sum   = a + b;
	assign diff  = a - b;
	assign lt_s  = ($signed(a) < $signed(b));
	assign lt_u  = (a < b);

	always_comb begin
		case (op)
			ALU_ADD:
				y = sum;
			ALU_SUB:
				y = diff;
			ALU_AND:
				y = a & b;
			ALU_OR:
				y = a | b;
			ALU_XOR:
				y = a ^ b;
			ALU_SLT:
				y = {{(XLEN-1){1'b0}}, lt_s};
			ALU_SLTU:
				y = {{(XLEN-1){1'b0}}, lt_u};
			ALU_SLL:
				y = a << shamt;
			ALU_SRL:
				y = a >> shamt;
			ALU_SRA:
				y = $signed(a) >>> shamt; // Sign bit fills from the left
			default:
				y = '0;
		endcase
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/100ps

module reg_file import rv_pkg::*; (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            we,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [4:0]      rd,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata1,
	output logic [XLEN-1:0] rdata2
);
	logic [XLEN-1:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rd != 5'd0)) begin
			regs[rd] <= wdata;
		end
	end

	// No bypass, the write lands after this cycle's read
	assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import rv_pkg::*; (
	input  logic [31:0]     inst,
	output ctrl_t           ctrl,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2,
	output logic [4:0]      rd,
	output logic [XLEN-1:0] imm
);
	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	// Shared by OP and OP_IMM, alt selects SUB or SRA
	function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd     = inst[11:7];
	assign rs2    = inst[24:20];
	// LUI reads x0 so the ALU can pass the immediate through an ADD
	assign rs1    = (opcode == OPC_LUI) ? 5'd0 : inst[19:15];

	always_comb begin
		case (opcode)
			OPC_STORE:
				imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
			OPC_BRANCH:
				imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			OPC_LUI, OPC_AUIPC:
				imm = {{32{inst[31]}}, inst[31:12], 12'b0};
			OPC_JAL:
				imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default:
				imm = {{52{inst[31]}}, inst[31:20]}; // I-type
		endcase
	end

	always_comb begin
		ctrl            = '0;
		ctrl.wb_sel     = WB_ALU;
		ctrl.alu_op     = ALU_ADD;
		ctrl.mem_funct3 = funct3;
		ctrl.br_funct3  = funct3;
		case (opcode)
			OPC_OP: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = alu_from_funct(funct3, funct7[5]);
			end
			OPC_OP_IMM: begin
				ctrl.reg_write = 1'b1;
				ctrl.b_is_imm  = 1'b1;
				// Bit 30 only means SRA for shifts, ADDI has no subtract form
				ctrl.alu_op    = alu_from_funct(funct3, (funct3 == 3'b101) && inst[30]);
			end
			OPC_LOAD: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_MEM;
				ctrl.b_is_imm  = 1'b1;
				ctrl.mem_read  = 1'b1;
			end
			OPC_STORE: begin
				ctrl.b_is_imm  = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			OPC_BRANCH:
				ctrl.is_branch = 1'b1; // Resolved in pc_unit
			OPC_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_LINK;
				ctrl.is_jal    = 1'b1;
			end
			OPC_JALR: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = WB_LINK;
				ctrl.b_is_imm  = 1'b1; // rs1 + imm is the target
				ctrl.is_jalr   = 1'b1;
			end
			OPC_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.b_is_imm  = 1'b1;
			end
			OPC_AUIPC: begin
				ctrl.reg_write = 1'b1;
				ctrl.a_is_pc   = 1'b1;
				ctrl.b_is_imm  = 1'b1;
			end
			OPC_SYSTEM:
				ctrl.halt = (inst[31:7] == 25'd0); // ECALL only
			default: ;
		endcase
	end

endmodule

// File: src/pc_unit.sv
`timescale 1ns/100ps

module pc_unit import rv_pkg::*; (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            step,
	input  ctrl_t           ctrl,
	input  logic [XLEN-1:0] imm,
	input  logic [XLEN-1:0] rs1_val,
	input  logic [XLEN-1:0] rs2_val,
	input  logic [XLEN-1:0] jalr_target,
	output logic [XLEN-1:0] pc
);
	logic            taken;
	logic [XLEN-1:0] pc_next;

	always_comb begin
		case (ctrl.br_funct3)
			3'b000:  taken = (rs1_val == rs2_val);                   // BEQ
			3'b001:  taken = (rs1_val != rs2_val);                   // BNE
			3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));  // BLT
			3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val)); // BGE
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (ctrl.is_jalr)
			pc_next = {jalr_target[XLEN-1:1], 1'b0};
		else if (ctrl.is_jal || (ctrl.is_branch && taken))
			pc_next = pc + imm;
		else
			pc_next = pc + XLEN'(4);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pc <= '0;
		else if (step)
			pc <= pc_next;
	end

	// A misaligned jump target would show up one edge later
	assert property (@(posedge clk) disable iff (!arst_n) step |=> (pc[1:0] == 2'b00))
		else $error("pc_unit: PC %h not word aligned", pc);

endmodule

// File: src/inst_mem.sv
`timescale 1ns/100ps

module inst_mem import rv_pkg::*; #(
	parameter  int IMEM_WORDS = 256,
	localparam int AW         = $clog2(IMEM_WORDS)
) (
	input  logic            clk,
	input  logic            load_en,
	input  logic [AW-1:0]   load_addr,
	input  logic [31:0]     load_data,
	input  logic [XLEN-1:0] pc,
	output logic [31:0]     inst
);
	logic [31:0] mem [IMEM_WORDS];
	logic        in_range;

	always_ff @(posedge clk) begin
		if (load_en && (load_addr < IMEM_WORDS))
			mem[load_addr] <= load_data;
	end

	assign in_range = (pc[XLEN-1:2] < IMEM_WORDS);
	assign inst     = in_range ? mem[pc[AW+1:2]] : 32'd0; // Zero word has no effect

endmodule

// File: src/data_mem.sv
`timescale 1ns/100ps

module data_mem import rv_pkg::*; #(
	parameter  int DMEM_WORDS = 128,
	localparam int AW         = $clog2(DMEM_WORDS)
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            we,
	input  logic            re,
	input  logic [2:0]      funct3,
	input  logic [XLEN-1:0] addr,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata
);
	logic [XLEN-1:0] mem [DMEM_WORDS];
	logic [AW-1:0]   idx;
	logic            in_range;
	logic [5:0]      bit_ofs;
	logic [7:0]      byte_mask;
	logic [XLEN-1:0] wdata_sh;
	logic [XLEN-1:0] rword;
	logic            aligned;

	assign idx      = addr[AW+2:3];
	assign in_range = (addr[XLEN-1:3] < DMEM_WORDS);
	assign bit_ofs  = {addr[2:0], 3'b000};
	assign wdata_sh = wdata << bit_ofs; // Lane the store data up to its byte

	always_comb begin
		case (funct3[1:0])
			2'b00:   byte_mask = 8'b0000_0001 << addr[2:0];
			2'b01:   byte_mask = 8'b0000_0011 << addr[2:0];
			2'b10:   byte_mask = 8'b0000_1111 << addr[2:0];
			default: byte_mask = 8'b1111_1111;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (we && in_range) begin
			for (int b = 0; b < 8; b++) begin
				if (byte_mask[b])
					mem[idx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
			end
		end
	end

	assign rword = in_range ? (mem[idx] >> bit_ofs) : '0;

	always_comb begin
		rdata = '0;
		if (re) begin
			case (funct3)
				3'b000:  rdata = {{56{rword[7]}}, rword[7:0]};   // LB
				3'b001:  rdata = {{48{rword[15]}}, rword[15:0]}; // LH
				3'b010:  rdata = {{32{rword[31]}}, rword[31:0]}; // LW
				3'b100:  rdata = {56'd0, rword[7:0]};            // LBU
				3'b101:  rdata = {48'd0, rword[15:0]};
				3'b110:  rdata = {32'd0, rword[31:0]};
				default: rdata = rword;                          // LD
			endcase
		end
	end

	always_comb begin
		case (funct3[1:0])
			2'b00:   aligned = 1'b1;
			2'b01:   aligned = (addr[0] == 1'b0);
			2'b10:   aligned = (addr[1:0] == 2'b00);
			default: aligned = (addr[2:0] == 3'b000);
		endcase
	end

	assert property (@(posedge clk) disable iff (!arst_n) (re || we) |-> aligned)
		else $error("data_mem: misaligned access at %h", addr);

endmodule

// File: src/rv_core_top.sv
`timescale 1ns/100ps

module rv_core_top import rv_pkg::*; #(
	parameter  int IMEM_WORDS = 256,
	parameter  int DMEM_WORDS = 128,
	localparam int IMEM_AW    = $clog2(IMEM_WORDS)
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               run,
	input  logic               load_en,
	input  logic [IMEM_AW-1:0] load_addr,
	input  logic [31:0]        load_data,
	output retire_t            retire,
	output logic               halted
);
	logic [31:0]     inst;
	ctrl_t           ctrl;
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [4:0]      rd;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] alu_a;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_y;
	logic [XLEN-1:0] mem_rdata;
	logic [XLEN-1:0] wb_data;
	logic            step;  // One instruction commits at the next edge
	logic            rf_we;

	assign step  = run && !halted;
	assign rf_we = step && ctrl.reg_write;

	inst_mem #(.IMEM_WORDS(IMEM_WORDS)) u_imem (
		.clk(clk), .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.pc(pc), .inst(inst)
	);

	inst_decoder u_dec (.inst(inst), .ctrl(ctrl), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm));

	reg_file u_rf (
		.clk(clk), .arst_n(arst_n), .we(rf_we), .rs1(rs1), .rs2(rs2), .rd(rd),
		.wdata(wb_data), .rdata1(rs1_val), .rdata2(rs2_val)
	);

	assign alu_a = ctrl.a_is_pc ? pc : rs1_val;
	assign alu_b = ctrl.b_is_imm ? imm : rs2_val;

	alu u_alu (.op(ctrl.alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

	pc_unit u_pc (
		.clk(clk), .arst_n(arst_n), .step(step), .ctrl(ctrl), .imm(imm),
		.rs1_val(rs1_val), .rs2_val(rs2_val), .jalr_target(alu_y), .pc(pc)
	);

	data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
		.clk(clk), .arst_n(arst_n), .we(step && ctrl.mem_write), .re(step && ctrl.mem_read),
		.funct3(ctrl.mem_funct3), .addr(alu_y), .wdata(rs2_val), .rdata(mem_rdata)
	);

	always_comb begin
		case (ctrl.wb_sel)
			WB_MEM:  wb_data = mem_rdata;
			WB_LINK: wb_data = pc + XLEN'(4);
			default: wb_data = alu_y;
		endcase
	end

	// Set by ECALL, held until reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			halted <= 1'b0;
		else if (step && ctrl.halt)
			halted <= 1'b1;
	end

	// A write to x0 reports rd 0 with zero data, since nothing lands
	always_comb begin
		retire.valid = step;
		retire.pc    = pc;
		retire.rd    = ctrl.reg_write ? rd : 5'd0;
		retire.wdata = (ctrl.reg_write && (rd != 5'd0)) ? wb_data : '0;
	end

endmodule

// File: bench/rv_checker.sv
`timescale 1ns/100ps

module rv_checker import rv_pkg::*; #(
	parameter int NROWS = 1
) (
	input logic                       clk,
	input logic                       arst_n,
	input retire_t                    retire,
	input logic                       halted,
	input logic [NROWS-1:0]           exp_ret,
	input logic [NROWS-1:0][XLEN-1:0] exp_pc,
	input logic [NROWS-1:0][4:0]      exp_rd,
	input logic [NROWS-1:0][XLEN-1:0] exp_wdata,
	input logic [NROWS-1:0][2:0]      exp_grp
);
	int row      = 0; // Next table row to match
	int n_pass   = 0;
	int n_fail   = 0;
	int grp_errs = 0;

	function automatic string group_name(input logic [2:0] g);
		case (g)
			3'd0:    return "register and immediate ALU ops";
			3'd1:    return "LUI and AUIPC";
			3'd2:    return "stores then loads";
			3'd3:    return "branches";
			3'd4:    return "JAL and JALR";
			default: return "ECALL halt";
		endcase
	endfunction

	// First row at or after r that is expected to retire
	function automatic int next_retiring(input int r);
		int n;
		n = r;
		while (n < NROWS && !exp_ret[n])
			n++;
		return n;
	endfunction

	task automatic compare(input string field, input logic [XLEN-1:0] expv,
			input logic [XLEN-1:0] actv);
		if (expv === actv) begin
			n_pass++;
		end else begin
			n_fail++;
			grp_errs++;
			$display("[FAIL] %0t ns: row %0d %s expected %h, got %h",
				$time, row, field, expv, actv);
		end
	endtask

	// Retire is stable mid-cycle, inputs move just after the rising edge
	always @(negedge clk) begin
		int nxt;
		if (!arst_n) begin
			if (retire.valid) begin
				$display("Retire valid was high during reset at %0t ns", $time);
				n_fail++;
			end
		end else if (retire.valid) begin
			row = next_retiring(row);
			if (row >= NROWS) begin
				$display("Unexpected retire at pc %h after the last table row", retire.pc);
				n_fail++;
			end else begin
				compare("pc", exp_pc[row], retire.pc);
				compare("rd", XLEN'(exp_rd[row]), XLEN'(retire.rd));
				compare("wdata", exp_wdata[row], retire.wdata);
				nxt = next_retiring(row + 1);
				if (nxt >= NROWS || exp_grp[nxt] != exp_grp[row]) begin
					if (grp_errs == 0)
						$display("Test %s: ok", group_name(exp_grp[row]));
					else
						$display("Test %s: %0d mismatches", group_name(exp_grp[row]), grp_errs);
					grp_errs = 0;
				end
				row++;
			end
		end
	end

	task automatic summarize();
		if (next_retiring(row) < NROWS) begin
			$display("Run ended before table row %0d retired", next_retiring(row));
			n_fail++;
		end
		if (!halted) begin
			$display("The core is not halted at the end of the run");
			n_fail++;
		end
		$display("Checks: %0d passed, %0d failed", n_pass, n_fail);
	endtask

endmodule

// File: bench/rv_tb.sv
`timescale 1ns/100ps

module rv_tb import rv_pkg::*; ();

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 128;
	localparam int NROWS      = 47;
	localparam int CLK_PERIOD = 4;

	logic                          clk = 1'b0;
	logic                          arst_n;
	logic                          run;
	logic                          load_en;
	logic [$clog2(IMEM_WORDS)-1:0] load_addr;
	logic [31:0]                   load_data;
	retire_t                       retire;
	logic                          halted;

	// Program table, one row per instruction word in program order
	logic [31:0]                prog [NROWS];
	logic [NROWS-1:0]           exp_ret;
	logic [NROWS-1:0][XLEN-1:0] exp_pc;
	logic [NROWS-1:0][4:0]      exp_rd;
	logic [NROWS-1:0][XLEN-1:0] exp_wdata;
	logic [NROWS-1:0][2:0]      exp_grp;
	int                         fill = 0;
	logic [11:0]                rnd_imm;

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic put_row(input logic [31:0] word, input logic ret, input logic [4:0] rd,
			input logic [XLEN-1:0] wdata, input logic [2:0] grp);
		prog[fill]      = word;
		exp_ret[fill]   = ret;
		exp_pc[fill]    = XLEN'(fill * 4); // Rows sit at consecutive word addresses
		exp_rd[fill]    = rd;
		exp_wdata[fill] = wdata;
		exp_grp[fill]   = grp;
		fill++;
	endtask

	task automatic build_program();
		logic [31:0] skip_word;
		skip_word = i_word(12'h001, 5'd0, 3'b000, 5'd27, OPC_OP_IMM); // Must never retire
		// ALU group with x1 = 0x12345678 and x2 = -5
		put_row(u_word(20'h12345, 5'd1, OPC_LUI), 1, 1, 64'h0000_0000_1234_5000, 0);
		put_row(i_word(12'h678, 5'd1, 3'b000, 5'd1, OPC_OP_IMM), 1, 1, 64'h1234_5678, 0);
		put_row(i_word(12'hffb, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), 1, 2, 64'hffff_ffff_ffff_fffb, 0);
		put_row(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1, 3, 64'h1234_5673, 0);
		put_row(r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1, 4, 64'h1234_567d, 0);
		put_row(r_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 1, 5, 64'h1234_5678, 0);
		put_row(r_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 1, 6, 64'hffff_ffff_ffff_fffb, 0);
		put_row(r_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 1, 7, 64'hffff_ffff_edcb_a983, 0);
		put_row(r_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 1, 8, 64'd1, 0);
		put_row(r_word(7'h00, 5'd1, 5'd2, 3'b011, 5'd9), 1, 9, 64'd0, 0);
		put_row(r_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd10), 1, 10, 64'hc000_0000_0000_0000, 0);
		put_row(i_word(12'h03c, 5'd2, 3'b101, 5'd11, OPC_OP_IMM), 1, 11, 64'hf, 0);
		put_row(i_word(12'h401, 5'd2, 3'b101, 5'd12, OPC_OP_IMM), 1, 12, 64'hffff_ffff_ffff_fffd, 0);
		put_row(i_word(12'h004, 5'd1, 3'b001, 5'd13, OPC_OP_IMM), 1, 13, 64'h1_2345_6780, 0);
		put_row(r_word(7'h20, 5'd11, 5'd10, 3'b101, 5'd14), 1, 14, 64'hffff_8000_0000_0000, 0);
		put_row(r_word(7'h00, 5'd11, 5'd10, 3'b101, 5'd15), 1, 15, 64'h0001_8000_0000_0000, 0);
		put_row(i_word(12'hffc, 5'd2, 3'b010, 5'd16, OPC_OP_IMM), 1, 16, 64'd1, 0);
		put_row(i_word(12'h0f0, 5'd1, 3'b111, 5'd17, OPC_OP_IMM), 1, 17, 64'h70, 0);
		put_row(i_word(12'h00f, 5'd1, 3'b110, 5'd18, OPC_OP_IMM), 1, 18, 64'h1234_567f, 0);
		put_row(i_word(12'hfff, 5'd1, 3'b100, 5'd19, OPC_OP_IMM), 1, 19, 64'hffff_ffff_edcb_a987, 0);
		put_row(i_word(rnd_imm, 5'd0, 3'b000, 5'd20, OPC_OP_IMM), 1, 20,
			XLEN'($signed(rnd_imm)), 0);
		// LUI sign-extends and ignores the x1 in its rs1 bits
		// AUIPC adds the pc (row 22 sits at 0x58)
		put_row(u_word(20'h80008, 5'd21, OPC_LUI), 1, 21, 64'hffff_ffff_8000_8000, 1);
		put_row(u_word(20'h00001, 5'd22, OPC_AUIPC), 1, 22, 64'h1058, 1);
		// Stores report rd 0 with zero data
		put_row(s_word(12'h040, 5'd19, 5'd0, 3'b011), 1, 0, 64'd0, 2);
		put_row(i_word(12'h040, 5'd0, 3'b011, 5'd23, OPC_LOAD), 1, 23, 64'hffff_ffff_edcb_a987, 2);
		put_row(s_word(12'h040, 5'd2, 5'd0, 3'b000), 1, 0, 64'd0, 2);
		put_row(i_word(12'h040, 5'd0, 3'b000, 5'd24, OPC_LOAD), 1, 24, 64'hffff_ffff_ffff_fffb, 2);
		put_row(i_word(12'h040, 5'd0, 3'b100, 5'd25, OPC_LOAD), 1, 25, 64'hfb, 2);
		put_row(s_word(12'h04c, 5'd21, 5'd0, 3'b010), 1, 0, 64'd0, 2);
		put_row(i_word(12'h04c, 5'd0, 3'b010, 5'd26, OPC_LOAD), 1, 26, 64'hffff_ffff_8000_8000, 2);
		// Taken branches skip one row each, BNE falls through
		put_row(b_word(13'd8, 5'd5, 5'd1, 3'b000), 1, 0, 64'd0, 3);
		put_row(skip_word, 0, 0, 64'd0, 3);
		put_row(b_word(13'd8, 5'd1, 5'd2, 3'b100), 1, 0, 64'd0, 3);
		put_row(skip_word, 0, 0, 64'd0, 3);
		put_row(b_word(13'd8, 5'd2, 5'd1, 3'b101), 1, 0, 64'd0, 3);
		put_row(skip_word, 0, 0, 64'd0, 3);
		put_row(b_word(13'd8, 5'd5, 5'd1, 3'b001), 1, 0, 64'd0, 3);
		put_row(i_word(12'h007, 5'd0, 3'b000, 5'd27, OPC_OP_IMM), 1, 27, 64'd7, 3);
		// JAL links pc+4, JALR to row 44 writes x0
		put_row(j_word(21'd8, 5'd28), 1, 28, 64'd156, 4);
		put_row(skip_word, 0, 0, 64'd0, 4);
		put_row(i_word(12'd176, 5'd0, 3'b000, 5'd29, OPC_OP_IMM), 1, 29, 64'd176, 4);
		put_row(i_word(12'h000, 5'd29, 3'b000, 5'd0, OPC_JALR), 1, 0, 64'd0, 4);
		put_row(skip_word, 0, 0, 64'd0, 4);
		put_row(skip_word, 0, 0, 64'd0, 4);
		put_row(i_word(12'h055, 5'd0, 3'b100, 5'd30, OPC_OP_IMM), 1, 30, 64'h55, 4);
		put_row(32'h0000_0073, 1, 0, 64'd0, 5); // ECALL
		put_row(skip_word, 0, 0, 64'd0, 5);
	endtask

	rv_core_top #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) DUT (
		.clk(clk), .arst_n(arst_n), .run(run), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .retire(retire), .halted(halted)
	);

	rv_checker #(.NROWS(NROWS)) chk (
		.clk(clk), .arst_n(arst_n), .retire(retire), .halted(halted),
		.exp_ret(exp_ret), .exp_pc(exp_pc), .exp_rd(exp_rd),
		.exp_wdata(exp_wdata), .exp_grp(exp_grp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		void'($urandom(32'hfa17));
		arst_n    = 1'b0;
		run       = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		rnd_imm   = 12'($urandom());
		build_program();
		repeat (10) @(posedge clk);
		#1 arst_n = 1'b1;
		for (int i = 0; i < NROWS; i++) begin
			@(posedge clk);
			#1;
			load_en   = 1'b1;
			load_addr = $bits(load_addr)'(i);
			load_data = prog[i];
		end
		@(posedge clk);
		#1;
		load_en = 1'b0;
		run     = 1'b1;
		wait (halted);
		repeat (10) @(posedge clk); // Margin for stray retires
		chk.summarize();
		if (chk.n_fail == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// Enough for every row plus some slack
	initial begin
		wait (run);
		#((NROWS + 20) * CLK_PERIOD);
		$display("Timeout: the core never halted within %0d cycles of run", NROWS + 20);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: tb.f
src/rv_pkg.sv
src/alu.sv
src/reg_file.sv
src/inst_decoder.sv
src/pc_unit.sv
src/inst_mem.sv
src/data_mem.sv
src/rv_core_top.sv
bench/rv_checker.sv
bench/rv_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/alu.sv
  - src/reg_file.sv
  - src/inst_decoder.sv
  - src/pc_unit.sv
  - src/inst_mem.sv
  - src/data_mem.sv
  - src/rv_core_top.sv
  - target: test
    files:
      - bench/rv_checker.sv
      - bench/rv_tb.sv
